/* hdl/alu_stage.sv */
// Execute stage: ALU, write-back port and registered retire outputs
`timescale 1ns/1ps

module alu_stage (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  exec_if.sink                                  ex,
  output logic                                  wb_en_o,
  output logic [exec_types_pkg::REG_ADDR_W-1:0] wb_addr_o,
  output logic [exec_types_pkg::XLEN-1:0]       wb_data_o,
  output logic                                  result_valid_o,
  output logic [exec_types_pkg::REG_ADDR_W-1:0] result_rd_o,
  output logic [exec_types_pkg::XLEN-1:0]       result_data_o,
  output logic                                  illegal_o
);
  import exec_types_pkg::*;

  logic [XLEN-1:0] alu_res;
  logic [4:0]      shamt;

  assign shamt = ex.op_b[4:0];

  always_comb begin
    case (ex.alu_op)
      ALU_ADD:  alu_res = ex.op_a + ex.op_b;
      ALU_SUB:  alu_res = ex.op_a - ex.op_b;
      ALU_SLL:  alu_res = ex.op_a << shamt;
      ALU_SRL:  alu_res = ex.op_a >> shamt;
      ALU_SRA:  alu_res = $unsigned($signed(ex.op_a) >>> shamt);
      ALU_AND:  alu_res = ex.op_a & ex.op_b;
      ALU_OR:   alu_res = ex.op_a | ex.op_b;
      ALU_XOR:  alu_res = ex.op_a ^ ex.op_b;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(ex.op_a) < $signed(ex.op_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, ex.op_a < ex.op_b};
      default:  alu_res = '0;
    endcase
  end

  // Write-back lands on the same edge as the retire registers
  assign wb_en_o   = ex.valid && ex.wen;
  assign wb_addr_o = ex.rd;
  assign wb_data_o = alu_res;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= ex.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex.valid) begin
      result_rd_o   <= ex.rd;
      result_data_o <= ex.illegal ? '0 : alu_res;
      illegal_o     <= ex.illegal;
    end
  end

  // x0 writes must already be stripped in decode
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_en_o |-> wb_addr_o != '0);

endmodule

/* hdl/control_unit.sv */
// Decode stage turning an instruction into registered controls, immediate and register selects
`timescale 1ns/1ps

module control_unit (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              instr_valid_i,
  input  logic [rv32i_isa_pkg::INSTR_W-1:0] instr_i,
  input  logic [exec_types_pkg::XLEN-1:0]   pc_i,
  decode_if.dec                             dec
);
  import rv32i_isa_pkg::*;
  import exec_types_pkg::*;

  rtype_t          r_fmt;
  itype_t          i_fmt;
  utype_t          u_fmt;
  opcode_e         opcode;
  funct3_alu_e     funct3;
  logic            alt;
  logic            shift_op;
  logic [XLEN-1:0] u_imm;
  logic            d_illegal;
  logic            d_wen;
  alu_op_e         d_alu_op;
  logic [XLEN-1:0] d_imm;
  opa_sel_e        d_opa_sel;
  opb_sel_e        d_opb_sel;

  assign r_fmt    = rtype_t'(instr_i);
  assign i_fmt    = itype_t'(instr_i);
  assign u_fmt    = utype_t'(instr_i);
  assign opcode   = opcode_e'(r_fmt.opcode);
  assign funct3   = funct3_alu_e'(r_fmt.funct3);
  assign alt      = |(r_fmt.funct7 & FUNCT7_ALT);
  assign shift_op = (funct3 == SLL) || (funct3 == SR);
  assign u_imm    = {u_fmt.imm31_12, {(XLEN-IMM_U_W){1'b0}}};

  // Only the four ALU classes execute
  always_comb begin
    case (opcode)
      REGREG:     d_illegal = r_fmt.funct7[0];
      IMMED:      d_illegal = shift_op && ((r_fmt.funct7 & ~FUNCT7_ALT) != '0);
      LUI, AUIPC: d_illegal = 1'b0;
      default:    d_illegal = 1'b1;
    endcase
  end

  assign d_wen = !d_illegal && (r_fmt.rd != '0);

  always_comb begin
    d_alu_op = ALU_ADD;
    if (opcode == REGREG || opcode == IMMED) begin
      case (funct3)
        ADDSUB:  d_alu_op = (opcode == REGREG && alt) ? ALU_SUB : ALU_ADD;
        SLL:     d_alu_op = ALU_SLL;
        SLT:     d_alu_op = ALU_SLT;
        SLTU:    d_alu_op = ALU_SLTU;
        XOR:     d_alu_op = ALU_XOR;
        SR:      d_alu_op = alt ? ALU_SRA : ALU_SRL;
        OR:      d_alu_op = ALU_OR;
        AND:     d_alu_op = ALU_AND;
        default: d_alu_op = ALU_ADD;
      endcase
    end
  end

  // Immediate and operand sources
  always_comb begin
    d_opa_sel = OPA_RS1;
    d_opb_sel = OPB_IMM;
    d_imm     = {{(XLEN-IMM_I_W){i_fmt.imm11_00[IMM_I_W-1]}}, i_fmt.imm11_00};
    case (opcode)
      REGREG: d_opb_sel = OPB_RS2;
      IMMED: begin
        if (shift_op) begin
          d_imm = {{(XLEN-SHAMT_W){1'b0}}, i_fmt.imm11_00[SHAMT_W-1:0]};
        end
      end
      LUI: begin
        d_opa_sel = OPA_ZERO;
        d_imm     = u_imm;
      end
      AUIPC: begin
        d_opa_sel = OPA_PC;
        d_imm     = u_imm;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      dec.rs1     <= r_fmt.rs1;
      dec.rs2     <= r_fmt.rs2;
      dec.rd      <= r_fmt.rd;
      dec.wen     <= d_wen;
      dec.illegal <= d_illegal;
      dec.imm     <= d_imm;
      dec.opa_sel <= d_opa_sel;
      dec.opb_sel <= d_opb_sel;
      dec.alu_op  <= d_alu_op;
      dec.pc      <= pc_i;
    end
  end

  // Strobed controls must come from a fully known instruction
  a_dec_ctrl_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dec.valid |-> !$isunknown({dec.wen, dec.illegal, dec.alu_op, dec.opa_sel, dec.opb_sel}));

endmodule

/* hdl/exec_types_pkg.sv */
// Data width, register count, ALU operation and operand select enums
package exec_types_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 1 << REG_ADDR_W;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SRL  = 4'd3,
    ALU_SRA  = 4'd4,
    ALU_AND  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_XOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  // Operand A source, LUI takes zero plus the U immediate
  typedef enum logic [1:0] {
    OPA_RS1  = 2'd0,
    OPA_PC   = 2'd1,
    OPA_ZERO = 2'd2
  } opa_sel_e;

  typedef enum logic {
    OPB_RS2 = 1'b0,
    OPB_IMM = 1'b1
  } opb_sel_e;

endpackage

/* hdl/operand_stage.sv */
// Operand read stage with register read, write-back forwarding and operand select
`timescale 1ns/1ps

module operand_stage (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  decode_if.opr                                 dec,
  output logic [exec_types_pkg::REG_ADDR_W-1:0] rs1_o,
  output logic [exec_types_pkg::REG_ADDR_W-1:0] rs2_o,
  input  logic [exec_types_pkg::XLEN-1:0]       rdata1_i,
  input  logic [exec_types_pkg::XLEN-1:0]       rdata2_i,
  input  logic                                  wb_en_i,
  input  logic [exec_types_pkg::REG_ADDR_W-1:0] wb_addr_i,
  input  logic [exec_types_pkg::XLEN-1:0]       wb_data_i,
  exec_if.src                                   ex
);
  import exec_types_pkg::*;

  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;

  // Result still in execute overrides the stale file value
  function automatic logic [XLEN-1:0] fwd(input logic [REG_ADDR_W-1:0] rs,
                                          input logic [XLEN-1:0]       rdata);
    if (wb_en_i && wb_addr_i == rs && rs != '0) begin
      return wb_data_i;
    end
    return rdata;
  endfunction

  assign rs1_o   = dec.rs1;
  assign rs2_o   = dec.rs2;

  always_comb begin
    rs1_val = fwd(dec.rs1, rdata1_i);
    rs2_val = fwd(dec.rs2, rdata2_i);
  end

  always_comb begin
    case (dec.opa_sel)
      OPA_RS1: op_a = rs1_val;
      OPA_PC:  op_a = dec.pc;
      default: op_a = '0;
    endcase
  end

  assign op_b = (dec.opb_sel == OPB_RS2) ? rs2_val : dec.imm;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex.valid <= 1'b0;
    end else begin
      ex.valid <= dec.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec.valid) begin
      ex.op_a    <= op_a;
      ex.op_b    <= op_b;
      ex.alu_op  <= dec.alu_op;
      ex.rd      <= dec.rd;
      ex.wen     <= dec.wen;
      ex.illegal <= dec.illegal;
    end
  end

endmodule

/* hdl/pipe_ifs.sv */
// Stage interfaces decode_if and exec_if with their modports
`timescale 1ns/1ps

// Decode to operand read
interface decode_if;
  import exec_types_pkg::*;

  logic                  valid;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic                  wen;
  logic                  illegal;
  logic [XLEN-1:0]       imm;
  opa_sel_e              opa_sel;
  opb_sel_e              opb_sel;
  alu_op_e               alu_op;
  logic [XLEN-1:0]       pc;

  modport dec (output valid, rs1, rs2, rd, wen, illegal, imm, opa_sel, opb_sel, alu_op, pc);
  modport opr (input valid, rs1, rs2, rd, wen, illegal, imm, opa_sel, opb_sel, alu_op, pc);
endinterface

// Operand read to execute
interface exec_if;
  import exec_types_pkg::*;

  logic                  valid;
  logic [XLEN-1:0]       op_a;
  logic [XLEN-1:0]       op_b;
  alu_op_e               alu_op;
  logic [REG_ADDR_W-1:0] rd;
  logic                  wen;
  logic                  illegal;

  modport src  (output valid, op_a, op_b, alu_op, rd, wen, illegal);
  modport sink (input valid, op_a, op_b, alu_op, rd, wen, illegal);
endinterface

/* hdl/reg_file.sv */
// Register file: 32 x XLEN, x0 hardwired to zero, two read ports, one write port
`timescale 1ns/1ps

module reg_file (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [exec_types_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [exec_types_pkg::REG_ADDR_W-1:0] rs2_i,
  output logic [exec_types_pkg::XLEN-1:0]       rdata1_o,
  output logic [exec_types_pkg::XLEN-1:0]       rdata2_o,
  input  logic                                wb_en_i,
  input  logic [exec_types_pkg::REG_ADDR_W-1:0] wb_addr_i,
  input  logic [exec_types_pkg::XLEN-1:0]       wb_data_i
);
  import exec_types_pkg::*;

  // No storage behind x0
  logic [XLEN-1:0] regs [1:NUM_REGS-1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en_i && wb_addr_i != '0) begin
      regs[wb_addr_i] <= wb_data_i;
    end
  end

  // Combinational reads
  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* hdl/rv32_exec_core.sv */
// Top level: decode, operand read and execute stages around the register file
`timescale 1ns/1ps

module rv32_exec_core (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  instr_valid_i,
  input  logic [rv32i_isa_pkg::INSTR_W-1:0]     instr_i,
  input  logic [exec_types_pkg::XLEN-1:0]       pc_i,
  output logic                                  result_valid_o,
  output logic [exec_types_pkg::REG_ADDR_W-1:0] result_rd_o,
  output logic [exec_types_pkg::XLEN-1:0]       result_data_o,
  output logic                                  illegal_o
);
  import exec_types_pkg::*;

  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [XLEN-1:0]       rdata1;
  logic [XLEN-1:0]       rdata2;
  logic                  wb_en;
  logic [REG_ADDR_W-1:0] wb_addr;
  logic [XLEN-1:0]       wb_data;

  decode_if dec_bus ();
  exec_if   ex_bus ();

  control_unit cu_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .dec           (dec_bus.dec)
  );

  reg_file rf_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rs1_i     (rs1),
    .rs2_i     (rs2),
    .rdata1_o  (rdata1),
    .rdata2_o  (rdata2),
    .wb_en_i   (wb_en),
    .wb_addr_i (wb_addr),
    .wb_data_i (wb_data)
  );

  // Write-back also feeds the forwarding path
  operand_stage opr_i (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .dec       (dec_bus.opr),
    .rs1_o     (rs1),
    .rs2_o     (rs2),
    .rdata1_i  (rdata1),
    .rdata2_i  (rdata2),
    .wb_en_i   (wb_en),
    .wb_addr_i (wb_addr),
    .wb_data_i (wb_data),
    .ex        (ex_bus.src)
  );

  alu_stage alu_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .ex             (ex_bus.sink),
    .wb_en_o        (wb_en),
    .wb_addr_o      (wb_addr),
    .wb_data_o      (wb_data),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o),
    .illegal_o      (illegal_o)
  );

endmodule

/* hdl/rv32i_isa_pkg.sv */
// RV32I opcode and funct3 enums, instruction formats and field widths
package rv32i_isa_pkg;

  localparam int INSTR_W     = 32;
  localparam int OPCODE_W    = 7;
  localparam int FUNCT3_W    = 3;
  localparam int FUNCT7_W    = 7;
  localparam int REG_FIELD_W = 5;
  localparam int SHAMT_W     = 5;
  localparam int IMM_I_W     = 12;
  localparam int IMM_U_W     = 20;

  // funct7 value that selects SUB and SRA
  localparam logic [FUNCT7_W-1:0] FUNCT7_ALT = 7'b0100000;

  typedef enum logic [OPCODE_W-1:0] {
    LOAD    = 7'b0000011,
    MISCMEM = 7'b0001111,
    IMMED   = 7'b0010011,
    AUIPC   = 7'b0010111,
    STORE   = 7'b0100011,
    REGREG  = 7'b0110011,
    LUI     = 7'b0110111,
    BRANCH  = 7'b1100011,
    JALR    = 7'b1100111,
    JAL     = 7'b1101111,
    SYSTEM  = 7'b1110011
  } opcode_e;

  typedef enum logic [FUNCT3_W-1:0] {
    ADDSUB = 3'd0,
    SLL    = 3'd1,
    SLT    = 3'd2,
    SLTU   = 3'd3,
    XOR    = 3'd4,
    SR     = 3'd5,
    OR     = 3'd6,
    AND    = 3'd7
  } funct3_alu_e;

  typedef struct packed {
    logic [FUNCT7_W-1:0]    funct7;
    logic [REG_FIELD_W-1:0] rs2;
    logic [REG_FIELD_W-1:0] rs1;
    logic [FUNCT3_W-1:0]    funct3;
    logic [REG_FIELD_W-1:0] rd;
    logic [OPCODE_W-1:0]    opcode;
  } rtype_t;

  typedef struct packed {
    logic [IMM_I_W-1:0]     imm11_00;
    logic [REG_FIELD_W-1:0] rs1;
    logic [FUNCT3_W-1:0]    funct3;
    logic [REG_FIELD_W-1:0] rd;
    logic [OPCODE_W-1:0]    opcode;
  } itype_t;

  typedef struct packed {
    logic [IMM_U_W-1:0]     imm31_12;
    logic [REG_FIELD_W-1:0] rd;
    logic [OPCODE_W-1:0]    opcode;
  } utype_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the rv32_exec_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f rv32_exec_core.f \
  --top-module rv32_exec_core_tb --Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/Vrv32_exec_core_tb > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see $SIM_LOG"
  exit 1
fi

if grep -q "TB FAILED" "$SIM_LOG"; then
  echo "Simulation failed, see $SIM_LOG"
  exit 1
fi
echo "Simulation passed"
exit 0

/* rv32_exec_core.f */
hdl/rv32i_isa_pkg.sv
hdl/exec_types_pkg.sv
hdl/pipe_ifs.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/operand_stage.sv
hdl/alu_stage.sv
hdl/rv32_exec_core.sv
tests/rv32_exec_core_tb.sv

/* tests/rv32_exec_core_tb.sv */
// Testbench for rv32_exec_core: vector file stimulus, random issue gaps, in-order retire checks
`timescale 1ns/1ps

module rv32_exec_core_tb;

  localparam int NUM_VEC    = 30;
  localparam int FIELDS     = 5;
  // Vectors 17 to 22 issue back to back to exercise forwarding
  localparam int B2B_FIRST  = 17;
  localparam int B2B_LAST   = 22;
  // Up to three cycles per vector, pipeline depth, then margin
  localparam int MAX_CYCLES = NUM_VEC * 3 + 3 + 20;

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        result_valid;
  logic [4:0]  result_rd;
  logic [31:0] result_data;
  logic        illegal;

  // Five words per vector: instr, pc, rd, data, illegal
  logic [31:0] vec_mem [0:NUM_VEC*FIELDS-1];
  int          seed;
  int          gap;
  int          n_retired  = 0;
  int          n_mismatch = 0;
  int          n_other    = 0;
  int          cycle_cnt  = 0;

  rv32_exec_core dut_i (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .pc_i           (pc),
    .result_valid_o (result_valid),
    .result_rd_o    (result_rd),
    .result_data_o  (result_data),
    .illegal_o      (illegal)
  );

  always #4 clk = ~clk;

  task automatic compare_field(input int idx, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch vector %0d %s: expected %h, actual %h", idx, field, expected, actual);
      n_mismatch++;
    end
  endtask

  task automatic print_counts();
    $display("mismatches: %0d, other errors: %0d, retired: %0d of %0d",
             n_mismatch, n_other, n_retired, NUM_VEC);
  endtask

  // Outputs move on the rising edge, so sample on the falling one
  always @(negedge clk) begin
    if (arst_n === 1'b1 && result_valid === 1'b1) begin
      if (n_retired < NUM_VEC) begin
        compare_field(n_retired, "rd", vec_mem[n_retired*FIELDS+2], {27'd0, result_rd});
        compare_field(n_retired, "data", vec_mem[n_retired*FIELDS+3], result_data);
        compare_field(n_retired, "illegal", vec_mem[n_retired*FIELDS+4], {31'd0, illegal});
      end else begin
        $display("error: retirement %0d arrived with no vector left to match", n_retired);
        n_other++;
      end
      n_retired++;
    end
  end

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    seed        = 32'hc79a_a7a3;
    $readmemh("tests/rv32_exec_vectors.hex", vec_mem);
    if ($isunknown(vec_mem[0])) begin
      $display("error: vector file did not load");
      n_other++;
    end
    repeat (8) @(negedge clk);
    arst_n = 1'b1;

    for (int i = 0; i < NUM_VEC; i++) begin
      if (i >= B2B_FIRST && i <= B2B_LAST) begin
        gap = 0;
      end else begin
        gap = $unsigned($random(seed)) % 3;
      end
      repeat (gap) @(negedge clk);
      instr_valid = 1'b1;
      instr       = vec_mem[i*FIELDS];
      pc          = vec_mem[i*FIELDS+1];
      @(negedge clk);
      instr_valid = 1'b0;
    end

    wait (n_retired >= NUM_VEC);
    // A few idle cycles to catch a spurious extra retirement
    repeat (6) @(negedge clk);
    if (n_retired != NUM_VEC) begin
      $display("error: %0d retirements for %0d vectors sent", n_retired, NUM_VEC);
      n_other++;
    end
    print_counts();
    if (n_mismatch == 0 && n_other == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (arst_n === 1'b1);
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("error: timeout after %0d cycles, retirements stopped at %0d of %0d",
             cycle_cnt, n_retired, NUM_VEC);
    n_other++;
    print_counts();
    $display("TB FAILED");
    $finish;
  end

endmodule

/* tests/rv32_exec_vectors.hex */
// Columns in hex: instruction, pc, expected rd, expected data, expected illegal flag
// Vectors 17 to 22 are issued back to back, 23 to 28 are flagged illegal
00500093 00000000 01 00000005 0 // addi  x1, x0, 5
ffd00113 00000004 02 fffffffd 0 // addi  x2, x0, -3
7f004193 00000008 03 000007f0 0 // xori  x3, x0, 0x7f0
f0006213 0000000c 04 ffffff00 0 // ori   x4, x0, -256
0ff17293 00000010 05 000000fd 0 // andi  x5, x2, 0xff
00409313 00000014 06 00000050 0 // slli  x6, x1, 4
40115393 00000018 07 fffffffe 0 // srai  x7, x2, 1
01c15413 0000001c 08 0000000f 0 // srli  x8, x2, 28
00012493 00000020 09 00000001 0 // slti  x9, x2, 0
00513513 00000024 0a 00000000 0 // sltiu x10, x2, 5
402085b3 00000028 0b 00000008 0 // sub   x11, x1, x2
00112633 0000002c 0c 00000001 0 // slt   x12, x2, x1
001136b3 00000030 0d 00000000 0 // sltu  x13, x2, x1
40125733 00000034 0e fffffff8 0 // sra   x14, x4, x1
001257b3 00000038 0f 07fffff8 0 // srl   x15, x4, x1
12345837 0000003c 10 12345000 0 // lui   x16, 0x12345
00001897 00000040 11 00001040 0 // auipc x17, 0x1
00608933 00000044 12 00000055 0 // add   x18, x1, x6
001919b3 00000048 13 00000aa0 0 // sll   x19, x18, x1
0129ca33 0000004c 14 00000af5 0 // xor   x20, x19, x18
007a0013 00000050 00 00000afc 0 // addi  x0, x20, 7
01406ab3 00000054 15 00000af5 0 // or    x21, x0, x20
003afb33 00000058 16 000002f0 0 // and   x22, x21, x3
0000ab83 0000005c 17 00000000 1 // lw    x23, 0(x1)
00112223 00000060 04 00000000 1 // sw    x1, 4(x2)
00108463 00000064 08 00000000 1 // beq   x1, x1, 8
010000ef 00000068 01 00000000 1 // jal   x1, 16
00000073 0000006c 00 00000000 1 // ecall
02108c33 00000070 18 00000000 1 // mul   x24, x1, x1
01708cb3 00000074 19 00000005 0 // add   x25, x1, x23
